/* common/spi_params.svh */
/*
  build constants for the spi hub
  frame width, routed peripheral count and pin synchronizer depth
*/

`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// bits per spi_cs frame, 4 address bits then 12 payload bits
`define SPI_FRAME_BITS 16

// downstream peripherals reachable through the cs2 passthrough
`define SPI_NUM_PERIPH 8

// flops per spi pin into the clk domain
`define SPI_SYNC_STAGES 2

`endif

/* common/spi_pkg.sv */
/*
  frame-level types for the spi_cs register path
  a frame is addr followed by a payload that decodes as value or as masks
*/

`include "spi_params.svh"

package spi_pkg;

  // register address field
  typedef logic [3:0] spi_addr_t;

  // payload and readback data word
  typedef logic [`SPI_FRAME_BITS-5:0] spi_data_t;

  // mask view of the payload
  // set and clear share a bit -> that bit toggles
  typedef struct packed {
    logic [3:0] rsvd;
    logic [3:0] set_mask;
    logic [3:0] clr_mask;
  } spi_mask_t;

  // same payload bits, two decodes
  // plain registers use value, led / out_en use masks
  typedef union packed {
    spi_data_t value;
    spi_mask_t masks;
  } spi_payload_u;

  // msb goes out first, so addr is the first nibble on the wire
  typedef struct packed {
    spi_addr_t    addr;
    spi_payload_u payload;
  } spi_frame_t;

endpackage

/* common/regmap_pkg.sv */
/*
  register map of the hub
  addresses, reset values and the register file struct used by reg_bank
*/

`include "spi_params.svh"

package regmap_pkg;

  // unlisted addresses are ignored on write and read back as zero
  typedef enum logic [3:0] {
    REG_LED     = 4'd1,
    REG_SPI_MUX = 4'd2,
    REG_OUT_EN  = 4'd3,
    REG_CS_POL  = 4'd4
  } reg_addr_e;

  // led and out_en are mask registers, the others plain
  typedef struct packed {
    logic [3:0]                 led;
    logic [7:0]                 spi_mux;
    logic [3:0]                 out_en;
    logic [`SPI_NUM_PERIPH-1:0] cs_pol;
  } regfile_t;

  // mux 0 selects nothing, pol 0 gives active low strobes
  localparam logic [3:0]                 LED_RST     = 4'h0;
  localparam logic [7:0]                 SPI_MUX_RST = 8'h00;
  localparam logic [3:0]                 OUT_EN_RST  = 4'h0;
  localparam logic [`SPI_NUM_PERIPH-1:0] CS_POL_RST  = '0;

  localparam regfile_t REGFILE_RST = '{
    led:     LED_RST,
    spi_mux: SPI_MUX_RST,
    out_en:  OUT_EN_RST,
    cs_pol:  CS_POL_RST
  };

endpackage

/* common/spi_if.sv */
/*
  internal buses of the spi_cs register path
  spi_sample_if carries synchronized pins and edge strobes
  spi_frame_if carries committed frames and the readback word
*/

`timescale 1ns/1ps

// sampler -> shifter, all strobes are single clk pulses
interface spi_sample_if;
  logic sclk_rise;
  logic sclk_fall;
  logic cs_start;
  logic cs_end;
  // level that is high while spi_cs is low
  logic cs_active;
  logic mosi;

  modport src (
    output sclk_rise, sclk_fall, cs_start, cs_end, cs_active, mosi
  );

  modport dst (
    input  sclk_rise, sclk_fall, cs_start, cs_end, cs_active, mosi
  );
endinterface

// shifter <-> reg_bank
interface spi_frame_if;
  import spi_pkg::*;

  logic       frame_valid;
  spi_frame_t frame;
  // address of the last committed frame
  spi_addr_t  rd_addr;
  // value of that register, combinational
  spi_data_t  rd_data;

  modport src (
    output frame_valid, frame, rd_addr,
    input  rd_data
  );

  modport dst (
    input  frame_valid, frame, rd_addr,
    output rd_data
  );
endinterface

/* hw/spi_slave/spi_sampler.sv */
/*
  brings the raw spi_cs bus pins into the clk domain
  strobes and levels all come out of one register stage, 3 clk after the pin
*/

`timescale 1ns/1ps
`include "spi_params.svh"

module spi_sampler (
  input  logic      clk,
  input  logic      rst,
  input  logic      spi_clk,
  input  logic      spi_cs,
  input  logic      spi_mosi,
  spi_sample_if.src smp
);

  localparam int SYNC_W = `SPI_SYNC_STAGES;

  // bit 0 takes the pin, top bit is the synchronized level
  logic [SYNC_W-1:0] clk_sync;
  logic [SYNC_W-1:0] cs_sync;
  logic [SYNC_W-1:0] mosi_sync;
  logic              clk_prev;
  logic              cs_prev;

  //////////////////////////////////////////////////
  // clock and chip select, edge detect

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // cs idles high, sclk idles low in mode 0
      clk_sync      <= '0;
      cs_sync       <= '1;
      clk_prev      <= 1'b0;
      cs_prev       <= 1'b1;
      smp.sclk_rise <= 1'b0;
      smp.sclk_fall <= 1'b0;
      smp.cs_start  <= 1'b0;
      smp.cs_end    <= 1'b0;
      smp.cs_active <= 1'b0;
    end
    else
    begin
      clk_sync <= {clk_sync[SYNC_W-2:0], spi_clk};
      cs_sync  <= {cs_sync[SYNC_W-2:0], spi_cs};
      clk_prev <= clk_sync[SYNC_W-1];
      cs_prev  <= cs_sync[SYNC_W-1];
      smp.sclk_rise <= clk_sync[SYNC_W-1] & ~clk_prev;
      smp.sclk_fall <= ~clk_sync[SYNC_W-1] & clk_prev;
      // cs is active low, falling edge starts a frame
      smp.cs_start  <= ~cs_sync[SYNC_W-1] & cs_prev;
      smp.cs_end    <= cs_sync[SYNC_W-1] & ~cs_prev;
      smp.cs_active <= ~cs_sync[SYNC_W-1];
    end
  end

  //////////////////////////////////////////////////
  // data pin

  // same depth as the strobes so mosi lines up with sclk_rise
  always_ff @(posedge clk)
  begin
    mosi_sync <= {mosi_sync[SYNC_W-2:0], spi_mosi};
    smp.mosi  <= mosi_sync[SYNC_W-1];
  end

endmodule

/* hw/spi_slave/frame_shifter.sv */
/*
  spi_cs frame engine, mode 0 msb first
  shifts mosi in and commits full frames, shifts the readback word out on dout
*/

`timescale 1ns/1ps
`include "spi_params.svh"

module frame_shifter (
  input  logic      clk,
  input  logic      rst,
  spi_sample_if.dst smp,
  spi_frame_if.src  frm,
  output logic      dout
);

  import spi_pkg::*;

  localparam int FB    = `SPI_FRAME_BITS;
  // one spare bit so over-long frames never wrap back to FB
  localparam int CNT_W = $clog2(FB) + 1;

  logic [FB-1:0]    rx_q;
  logic [FB-1:0]    tx_q;
  logic [CNT_W-1:0] bit_cnt;
  logic             frame_ok;
  spi_frame_t       rx_frame;

  assign rx_frame  = spi_frame_t'(rx_q);
  assign frm.frame = rx_frame;

  // only exactly FB rising edges make a frame
  assign frame_ok = smp.cs_end && (bit_cnt == CNT_W'(FB));

  //////////////////////////////////////////////////
  // receive

  // rx_q holds still after cs_end until the next frame clocks in
  always_ff @(posedge clk)
  begin
    if (smp.cs_active && smp.sclk_rise)
      rx_q <= {rx_q[FB-2:0], smp.mosi};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      bit_cnt <= '0;
    else if (smp.cs_start)
      bit_cnt <= '0;
    // saturate
    else if (smp.cs_active && smp.sclk_rise && bit_cnt != '1)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // commit happens one cycle after cs_end
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      frm.frame_valid <= 1'b0;
      frm.rd_addr     <= '0;
    end
    else
    begin
      frm.frame_valid <= frame_ok;
      // next frame reads back this address
      if (frame_ok)
        frm.rd_addr <= rx_frame.addr;
    end
  end

  //////////////////////////////////////////////////
  // transmit

  // load {addr, data} at frame start, msb is out before the first rising sclk
  // each falling sclk moves the next bit up
  always_ff @(posedge clk)
  begin
    if (smp.cs_start)
      tx_q <= {frm.rd_addr, frm.rd_data};
    else if (smp.cs_active && smp.sclk_fall)
      tx_q <= {tx_q[FB-2:0], 1'b0};
  end

  // low while not selected
  assign dout = smp.cs_active & tx_q[FB-1];

endmodule

/* hw/reg_bank/reg_bank.sv */
/*
  hub register bank, written by committed spi_cs frames
  led and out_en use set/clear/toggle masks, spi_mux and cs_pol take a value
*/

`timescale 1ns/1ps

module reg_bank (
  input  logic                clk,
  input  logic                rst,
  spi_frame_if.dst            frm,
  output regmap_pkg::regfile_t regs
);

  import spi_pkg::*;
  import regmap_pkg::*;

  spi_payload_u payload;
  reg_addr_e    wr_addr;
  reg_addr_e    rd_addr;

  assign payload = frm.frame.payload;
  assign wr_addr = reg_addr_e'(frm.frame.addr);
  assign rd_addr = reg_addr_e'(frm.rd_addr);

  // bits in both masks toggle and nothing else moves
  // otherwise set first, then clear, so clear wins
  function automatic logic [3:0] mask_update(
    input logic [3:0] cur,
    input logic [3:0] set_m,
    input logic [3:0] clr_m
  );
    logic [3:0] both;
    both = set_m & clr_m;
    if (both != 4'h0)
      return cur ^ both;
    else
      return (cur | set_m) & ~clr_m;
  endfunction

  //////////////////////////////////////////////////
  // write

  // takes effect the cycle after frame_valid
  always_ff @(posedge clk)
  begin
    if (rst)
      regs <= REGFILE_RST;
    else if (frm.frame_valid)
    begin
      case (wr_addr)
        REG_LED:
          regs.led <= mask_update(regs.led, payload.masks.set_mask,
                                  payload.masks.clr_mask);
        REG_OUT_EN:
          regs.out_en <= mask_update(regs.out_en, payload.masks.set_mask,
                                     payload.masks.clr_mask);
        // plain registers keep the low byte
        REG_SPI_MUX:
          regs.spi_mux <= payload.value[7:0];
        REG_CS_POL:
          regs.cs_pol <= payload.value[$bits(regs.cs_pol)-1:0];
        // unknown addresses are dropped
        default:
        begin
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // readback

  // zero extended into the payload width
  always_comb
  begin
    frm.rd_data = '0;
    case (rd_addr)
      REG_LED:     frm.rd_data = spi_data_t'(regs.led);
      REG_SPI_MUX: frm.rd_data = spi_data_t'(regs.spi_mux);
      REG_OUT_EN:  frm.rd_data = spi_data_t'(regs.out_en);
      REG_CS_POL:  frm.rd_data = spi_data_t'(regs.cs_pol);
      default:     frm.rd_data = '0;
    endcase
  end

endmodule

/* hw/spi_router.sv */
/*
  cs2 passthrough to the downstream peripherals, purely combinational
  routes raw sclk, mosi and a polarity-adjusted strobe, muxes miso back
*/

`timescale 1ns/1ps
`include "spi_params.svh"

module spi_router (
  input  logic [7:0]                 spi_mux,
  input  logic [`SPI_NUM_PERIPH-1:0] cs_pol,
  input  logic                       spi_cs2,
  input  logic                       spi_clk,
  input  logic                       spi_mosi,
  input  logic                       dout,
  input  logic [`SPI_NUM_PERIPH-1:0] periph_miso,
  output logic [`SPI_NUM_PERIPH-1:0] periph_cs,
  output logic [`SPI_NUM_PERIPH-1:0] periph_clk,
  output logic [`SPI_NUM_PERIPH-1:0] periph_mosi,
  output logic                       spi_miso
);

  localparam int NP = `SPI_NUM_PERIPH;

  logic [NP-1:0] sel;
  logic [NP-1:0] cs_on;

  // mux value n picks peripheral n-1
  // 0 and anything past NP pick none
  always_comb
  begin
    sel = '0;
    for (int i = 0; i < NP; i++)
      sel[i] = (spi_mux == 8'(i + 1));
  end

  // cs2 is active low from the mcu
  assign cs_on = sel & {NP{~spi_cs2}};

  // pol bit 1 flips that line to an active high strobe, e.g. 4094 latch
  assign periph_cs = ~(cs_on ^ cs_pol);

  // unselected lines sit at 0
  assign periph_clk  = sel & {NP{spi_clk}};
  assign periph_mosi = sel & {NP{spi_mosi}};

  // cs2 idle means the mcu is talking to the hub itself
  assign spi_miso = spi_cs2 ? dout : |(sel & periph_miso);

endmodule

/* hw/spi_hub_top.sv */
/*
  spi peripheral hub top level
  spi_cs frames program the register bank, spi_cs2 passes the bus downstream
*/

`timescale 1ns/1ps
`include "spi_params.svh"

module spi_hub_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       spi_clk,
  input  logic                       spi_cs,
  input  logic                       spi_cs2,
  input  logic                       spi_mosi,
  input  logic [`SPI_NUM_PERIPH-1:0] periph_miso,
  output logic                       spi_miso,
  output logic [`SPI_NUM_PERIPH-1:0] periph_cs,
  output logic [`SPI_NUM_PERIPH-1:0] periph_clk,
  output logic [`SPI_NUM_PERIPH-1:0] periph_mosi,
  output logic [3:0]                 led,
  output logic [3:0]                 out_en
);

  import regmap_pkg::*;

  spi_sample_if smp ();
  spi_frame_if  frm ();

  regfile_t regs;
  // hub's own miso, before the cs2 mux
  logic     dout;

  //////////////////////////////////////////////////
  // register path, clk domain

  spi_sampler u_sampler (
    .clk      (clk),
    .rst      (rst),
    .spi_clk  (spi_clk),
    .spi_cs   (spi_cs),
    .spi_mosi (spi_mosi),
    .smp      (smp.src)
  );

  frame_shifter u_shifter (
    .clk  (clk),
    .rst  (rst),
    .smp  (smp.dst),
    .frm  (frm.src),
    .dout (dout)
  );

  reg_bank u_regs (
    .clk  (clk),
    .rst  (rst),
    .frm  (frm.dst),
    .regs (regs)
  );

  assign led    = regs.led;
  assign out_en = regs.out_en;

  //////////////////////////////////////////////////
  // passthrough, raw pins

  spi_router u_router (
    .spi_mux     (regs.spi_mux),
    .cs_pol      (regs.cs_pol),
    .spi_cs2     (spi_cs2),
    .spi_clk     (spi_clk),
    .spi_mosi    (spi_mosi),
    .dout        (dout),
    .periph_miso (periph_miso),
    .periph_cs   (periph_cs),
    .periph_clk  (periph_clk),
    .periph_mosi (periph_mosi),
    .spi_miso    (spi_miso)
  );

endmodule

/* bench/spi_hub_tb.sv */
/*
  directed testbench for the spi hub
  an spi master model writes and reads the register bank over spi_cs
  and then the cs2 passthrough and chip select polarity are exercised
*/

`timescale 1ns/1ps
`include "spi_params.svh"

module spi_hub_tb;

  import regmap_pkg::*;

  localparam int NP             = `SPI_NUM_PERIPH;
  // spi_clk half period in clk cycles
  localparam int HALF           = 8;
  localparam int MAX_FRAMES     = 40;
  localparam int FRAME_CYCLES   = 300;
  localparam int TIMEOUT_CYCLES = MAX_FRAMES * FRAME_CYCLES;

  logic          clk;
  logic          rst;
  logic          spi_clk;
  logic          spi_cs;
  logic          spi_cs2;
  logic          spi_mosi;
  logic [NP-1:0] periph_miso;
  logic          spi_miso;
  logic [NP-1:0] periph_cs;
  logic [NP-1:0] periph_clk;
  logic [NP-1:0] periph_mosi;
  logic [3:0]    led;
  logic [3:0]    out_en;

  // reference register model
  logic [3:0]    m_led;
  logic [3:0]    m_out_en;
  logic [7:0]    m_mux;
  logic [NP-1:0] m_pol;
  // address of the last full frame, read back by the next one
  logic [3:0]    last_addr;

  int cycles;

  spi_hub_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .spi_clk     (spi_clk),
    .spi_cs      (spi_cs),
    .spi_cs2     (spi_cs2),
    .spi_mosi    (spi_mosi),
    .periph_miso (periph_miso),
    .spi_miso    (spi_miso),
    .periph_cs   (periph_cs),
    .periph_clk  (periph_clk),
    .periph_mosi (periph_mosi),
    .led         (led),
    .out_en      (out_en)
  );

  //////////////////////////////////////////////////
  // clock and run limit

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d clk cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "run limit reached");
    end
  end

  //////////////////////////////////////////////////
  // checking and reference model

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // overlap toggles the shared bits only, else set then clear per bit
  function automatic logic [3:0] mask_rule(input logic [3:0] cur, input logic [3:0] set_m,
                                           input logic [3:0] clr_m);
    logic [3:0] res;
    res = cur;
    for (int i = 0; i < 4; i++)
    begin
      if ((set_m & clr_m) != 4'h0)
        res[i] = (set_m[i] && clr_m[i]) ? ~cur[i] : cur[i];
      else if (clr_m[i])
        res[i] = 1'b0;
      else if (set_m[i])
        res[i] = 1'b1;
    end
    return res;
  endfunction

  // unmapped addresses read as zero
  function automatic logic [11:0] model_read(input logic [3:0] a);
    case (a)
      REG_LED:     return {8'h00, m_led};
      REG_SPI_MUX: return {4'h0, m_mux};
      REG_OUT_EN:  return {8'h00, m_out_en};
      REG_CS_POL:  return {4'h0, m_pol};
      default:     return 12'h000;
    endcase
  endfunction

  task automatic model_write(input logic [3:0] a, input logic [11:0] p);
    case (a)
      REG_LED:     m_led = mask_rule(m_led, p[7:4], p[3:0]);
      REG_OUT_EN:  m_out_en = mask_rule(m_out_en, p[7:4], p[3:0]);
      REG_SPI_MUX: m_mux = p[7:0];
      REG_CS_POL:  m_pol = p[NP-1:0];
      default:     ;
    endcase
    last_addr = a;
  endtask

  //////////////////////////////////////////////////
  // spi master, mode 0, msb first

  // sends the top nbits of tx, returns what came back on miso
  task automatic spi_xfer(input logic [15:0] tx, input int nbits, output logic [15:0] rx);
    rx = '0;
    @(negedge clk);
    spi_cs = 1'b0;
    repeat (HALF) @(negedge clk);
    for (int b = 0; b < nbits; b++)
    begin
      spi_mosi = tx[15-b];
      repeat (HALF) @(negedge clk);
      // miso has settled and is taken with the rising edge
      rx = {rx[14:0], spi_miso};
      spi_clk = 1'b1;
      repeat (HALF) @(negedge clk);
      spi_clk = 1'b0;
    end
    repeat (HALF) @(negedge clk);
    spi_cs   = 1'b1;
    spi_mosi = 1'b0;
    // register update is due 5 cycles after cs rises
    repeat (6) @(negedge clk);
  endtask

  // full frame, checks the readback word and the mask outputs
  task automatic send_write(input logic [3:0] a, input logic [11:0] p);
    logic [15:0] rx;
    logic [15:0] exp_rx;
    exp_rx = {last_addr, model_read(last_addr)};
    spi_xfer({a, p}, 16, rx);
    check(rx, exp_rx, "readback word");
    model_write(a, p);
    check(led, m_led, "led");
    check(out_en, m_out_en, "out_en");
  endtask

  //////////////////////////////////////////////////
  // tests

  task automatic after_reset_test();
    check(led, 4'h0, "led after reset");
    check(out_en, 4'h0, "out_en after reset");
    check(periph_clk, '0, "periph_clk after reset");
    check(periph_mosi, '0, "periph_mosi after reset");
    check(periph_cs, {NP{1'b1}}, "periph_cs after reset");
    check(spi_miso, 1'b0, "spi_miso after reset");
  endtask

  task automatic mask_test();
    logic [3:0] set_m;
    logic [3:0] clr_m;
    logic [3:0] a;
    int         bit_i;
    for (int i = 0; i < 12; i++)
    begin
      a     = (i % 2 == 1) ? REG_OUT_EN : REG_LED;
      set_m = 4'($urandom);
      clr_m = 4'($urandom);
      // every third frame forces an overlap so the toggle case is hit
      if (i % 3 == 0)
      begin
        bit_i        = $urandom % 4;
        set_m[bit_i] = 1'b1;
        clr_m[bit_i] = 1'b1;
      end
      send_write(a, {4'($urandom), set_m, clr_m});
    end
  endtask

  task automatic readback_test();
    logic [15:0] rx;
    send_write(REG_LED, 12'h0A0);
    send_write(REG_SPI_MUX, 12'h0A5);
    send_write(REG_OUT_EN, 12'h060);
    send_write(REG_CS_POL, 12'h03C);
    // address 9 is unmapped so the next frame reads back {9, 0}
    send_write(4'h9, 12'hFFF);
    // a 12 bit frame must not commit
    spi_xfer({REG_LED, 12'h0F0}, 12, rx);
    check(led, m_led, "led after short frame");
    check(out_en, m_out_en, "out_en after short frame");
    // readback still points at address 9
    send_write(REG_CS_POL, 12'h000);
  endtask

  // drives the passthrough with peripheral n selected, cs2 low
  task automatic route_step(input int n, input int k);
    logic [NP-1:0] onehot;
    logic [NP-1:0] exp_cs;
    logic          miso_bit;
    onehot = NP'(1) << (n - 1);
    // selected line strobes at its pol level while the others idle at the inverse
    exp_cs      = ~m_pol;
    exp_cs[n-1] = m_pol[n-1];
    @(negedge clk);
    spi_clk  = 1'($urandom);
    spi_mosi = 1'($urandom);
    if (k < 2)
    begin
      // other lines sit at the opposite level and must not leak through
      miso_bit       = k[0];
      periph_miso    = {NP{~miso_bit}};
      periph_miso[n-1] = miso_bit;
    end
    else
    begin
      periph_miso = NP'($urandom);
      miso_bit    = periph_miso[n-1];
    end
    @(posedge clk);
    check(periph_clk, spi_clk ? onehot : '0, "periph_clk routing");
    check(periph_mosi, spi_mosi ? onehot : '0, "periph_mosi routing");
    check(spi_miso, miso_bit, "spi_miso from peripheral");
    check(periph_cs, exp_cs, "periph_cs active");
  endtask

  task automatic routing_test();
    logic [NP-1:0] idle_cs;
    for (int n = 1; n <= NP; n++)
    begin
      send_write(REG_SPI_MUX, 12'(n));
      @(negedge clk);
      spi_cs2 = 1'b0;
      for (int k = 0; k < 4; k++)
        route_step(n, k);
      @(negedge clk);
      spi_cs2     = 1'b1;
      spi_clk     = 1'b0;
      spi_mosi    = 1'b0;
      periph_miso = '0;
      @(posedge clk);
      idle_cs = ~m_pol;
      check(periph_cs, idle_cs, "periph_cs idle");
      check(spi_miso, 1'b0, "spi_miso idle");
    end
  endtask

  task automatic polarity_test();
    logic [11:0]   pol;
    logic [NP-1:0] idle_cs;
    for (int i = 0; i < 3; i++)
    begin
      pol = (i == 2) ? 12'h000 : 12'(8'($urandom));
      send_write(REG_CS_POL, pol);
      // idle level follows the written bits only
      idle_cs = ~m_pol;
      check(periph_cs, idle_cs, "periph_cs idle with polarity");
      @(negedge clk);
      spi_cs2 = 1'b0;
      route_step(m_mux, 2);
      @(negedge clk);
      spi_cs2 = 1'b1;
      spi_clk = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial
  begin
    void'($urandom(32'h8d6d_f1bc));
    cycles      = 0;
    rst         = 1'b1;
    spi_clk     = 1'b0;
    spi_cs      = 1'b1;
    spi_cs2     = 1'b1;
    spi_mosi    = 1'b0;
    periph_miso = '0;
    m_led       = '0;
    m_out_en    = '0;
    m_mux       = '0;
    m_pol       = '0;
    last_addr   = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    after_reset_test();
    mask_test();
    readback_test();
    routing_test();
    polarity_test();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* tb.f */
+incdir+common
common/spi_pkg.sv
common/regmap_pkg.sv
common/spi_if.sv
hw/spi_slave/spi_sampler.sv
hw/spi_slave/frame_shifter.sv
hw/reg_bank/reg_bank.sv
hw/spi_router.sv
hw/spi_hub_top.sv
bench/spi_hub_tb.sv

/* Makefile */
SIM     = verilator
FLAGS   = --binary --timing -Wno-fatal
TOP     = spi_hub_tb
FLIST   = tb.f
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "*** PASSED ***" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
